/* sources.f */
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_datapath.sv
hw/icache_control.sv
hw/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

/* bench/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int num_sets   = 8;
    localparam int seed_init  = 56117;
    localparam int num_random = 300;
    // data rule of the memory, known here on its own
    localparam logic [31:0] pattern_key = 32'h5a3c_96e1;

    logic  clk;
    logic  arst_n;
    logic  mem_read;
    addr_t mem_address;
    word_t mem_rdata;
    logic  mem_resp;
    logic  pmem_read;
    addr_t pmem_address;
    line_t pmem_rdata;
    logic  pmem_resp;

    integer seed;

    // reference state per set and way
    logic        model_valid [num_sets][2];
    logic [23:0] model_tag   [num_sets][2];
    logic        model_lru   [num_sets];

    // small pool so sets conflict
    logic [23:0] tag_pool [4];

    icache_top #(
        .num_sets (num_sets)
    ) dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_address  (mem_address),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_address (pmem_address),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    icache_mem_model #(
        .latency_seed (seed_init)
    ) mem_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .pmem_read    (pmem_read),
        .pmem_address (pmem_address),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    always #5 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic word_t expected_word(addr_t addr);
        return {addr[31:2], 2'b00} ^ pattern_key;
    endfunction

    task automatic clear_model();
        for (int s = 0; s < num_sets; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_tag[s][0]   = '0;
            model_tag[s][1]   = '0;
            model_lru[s]      = 1'b0;
        end
    endtask

    // one cycle with no request, cache must stay quiet
    task automatic quiet_cycle();
        @(negedge clk);
        assert (!mem_resp && !pmem_read)
            else report_error("cache active without a request");
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        arst_n   = 1'b0;
        mem_read = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (!mem_resp && !pmem_read)
                else report_error("mem_resp or pmem_read high during reset");
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        clear_model();
        // right after release
        quiet_cycle();
        quiet_cycle();
    endtask

    // issue one read, hold until mem_resp, check against the model
    task automatic run_request(input addr_t addr, output logic was_hit);
        logic [2:0]  set;
        logic [23:0] tag;
        logic        predict_hit;
        logic        hit_way;
        logic        victim;
        logic        prev_pread;
        logic        done;
        int          cycles;
        int          fetches;
        addr_t       line_addr;
        set         = addr[7:5];
        tag         = addr[31:8];
        line_addr   = {addr[31:5], 5'b0};
        predict_hit = 1'b0;
        hit_way     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[set][w] && (model_tag[set][w] == tag)) begin
                predict_hit = 1'b1;
                hit_way     = w[0];
            end
        end
        mem_read    = 1'b1;
        mem_address = addr;
        cycles      = 0;
        fetches     = 0;
        prev_pread  = 1'b0;
        done        = 1'b0;
        while (!done) begin
            // outputs are settled half a cycle after the drive point
            @(negedge clk);
            assert (!(mem_resp && pmem_read))
                else report_error("mem_resp and pmem_read high in the same cycle");
            if (pmem_read && !prev_pread) begin
                fetches++;
                assert (pmem_address == line_addr)
                    else report_error($sformatf("ERROR pmem_address got %h expected %h",
                        pmem_address, line_addr));
            end
            prev_pread = pmem_read;
            if (mem_resp) begin
                done = 1'b1;
                assert (mem_rdata == expected_word(addr))
                    else report_error($sformatf("ERROR mem_rdata got %h expected %h",
                        mem_rdata, expected_word(addr)));
            end else begin
                cycles++;
                assert (cycles < 50)
                    else report_error("no response from cache");
            end
            @(posedge clk);
            #1;
        end
        mem_read = 1'b0;
        if (predict_hit) begin
            assert ((cycles == 0) && (fetches == 0))
                else report_error($sformatf("expected hit at %h, got a fetch or a late response",
                    addr));
            // the other way becomes the victim
            model_lru[set] = ~hit_way;
        end else begin
            assert (fetches == 1)
                else report_error($sformatf("expected one fetch for miss at %h, saw %0d",
                    addr, fetches));
            victim                   = model_lru[set];
            model_valid[set][victim] = 1'b1;
            model_tag[set][victim]   = tag;
            model_lru[set]           = ~victim;
        end
        was_hit = (fetches == 0);
    endtask

    initial begin
        addr_t seq_addr [6];
        logic  seq_hit  [6];
        logic  was_hit;
        addr_t addr;
        int    gap;
        clk         = 1'b0;
        arst_n      = 1'b0;
        mem_read    = 1'b0;
        mem_address = '0;
        seed        = seed_init;
        tag_pool[0] = 24'h000a11;
        tag_pool[1] = 24'h000b22;
        tag_pool[2] = 24'h000c33;
        tag_pool[3] = 24'h3f0d44;

        apply_reset();

        // A B A C A B in set 3, C pushes out B
        seq_addr[0] = {tag_pool[0], 3'd3, 3'd1, 2'b00};
        seq_addr[1] = {tag_pool[1], 3'd3, 3'd2, 2'b00};
        seq_addr[2] = {tag_pool[0], 3'd3, 3'd5, 2'b00};
        seq_addr[3] = {tag_pool[2], 3'd3, 3'd0, 2'b00};
        seq_addr[4] = {tag_pool[0], 3'd3, 3'd7, 2'b00};
        seq_addr[5] = {tag_pool[1], 3'd3, 3'd4, 2'b00};
        seq_hit[0]  = 1'b0;
        seq_hit[1]  = 1'b0;
        seq_hit[2]  = 1'b1;
        seq_hit[3]  = 1'b0;
        seq_hit[4]  = 1'b1;
        seq_hit[5]  = 1'b0;
        for (int i = 0; i < 6; i++) begin
            run_request(seq_addr[i], was_hit);
            assert (was_hit == seq_hit[i])
                else report_error($sformatf(
                    "replacement step %0d at %h hit when it should miss, or the reverse",
                    i, seq_addr[i]));
        end

        // random stream, back to back or with short gaps
        for (int n = 0; n < num_random; n++) begin
            addr = {tag_pool[$unsigned($random(seed)) % 4],
                    3'($unsigned($random(seed)) % 8),
                    3'($unsigned($random(seed)) % 8),
                    2'b00};
            run_request(addr, was_hit);
            gap = $unsigned($random(seed)) % 3;
            for (int g = 0; g < gap; g++) begin
                quiet_cycle();
            end
        end

        // make the probed lines resident so stale valid bits would hit
        for (int s = 0; s < num_sets; s++) begin
            addr = {tag_pool[s % 4], 3'(s), 3'd2, 2'b00};
            run_request(addr, was_hit);
        end

        // every line is empty again after a second reset
        apply_reset();
        for (int s = 0; s < num_sets; s++) begin
            addr = {tag_pool[s % 4], 3'(s), 3'd2, 2'b00};
            run_request(addr, was_hit);
            assert (!was_hit)
                else report_error($sformatf("first access at %h after reset did not miss", addr));
        end

        $display("test passed");
        $finish;
    end

endmodule

/* bench/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model
    import icache_pkg::*;
#(
    parameter int latency_seed = 1
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  pmem_read,
    input  addr_t pmem_address,
    output line_t pmem_rdata,
    output logic  pmem_resp
);

    // each word is its own byte address mixed with this key
    localparam logic [31:0] pattern_key = 32'h5a3c_96e1;

    integer seed;

    // build the full line for a line-aligned address
    function automatic line_t line_pattern(addr_t base);
        line_t line;
        addr_t aligned;
        aligned = {base[31:offset_bits], {offset_bits{1'b0}}};
        line = '0;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = (aligned + 32'(w * 4)) ^ pattern_key;
        end
        return line;
    endfunction

    initial begin
        int latency;
        seed       = latency_seed;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(posedge clk);
            // look at the request once the cache outputs have settled
            #1;
            if (pmem_read && arst_n) begin
                // 1 to 6 cycles of fill
                latency = 1 + ($unsigned($random(seed)) % 6);
                for (int i = 1; i < latency; i++) begin
                    @(posedge clk);
                    #1;
                end
                pmem_rdata = line_pattern(pmem_address);
                pmem_resp  = 1'b1;
                @(posedge clk);
                #1;
                // single-cycle strobe
                pmem_resp  = 1'b0;
                pmem_rdata = '0;
            end
        end
    end

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int num_sets = 8
) (
    input  logic  clk,
    input  logic  arst_n,
    // processor side
    input  logic  mem_read,
    input  addr_t mem_address,
    output word_t mem_rdata,
    output logic  mem_resp,
    // physical memory side
    output logic  pmem_read,
    output addr_t pmem_address,
    input  line_t pmem_rdata,
    input  logic  pmem_resp
);

    // control to datapath
    icache_ctrl_t   ctrl;
    // datapath to control
    icache_status_t status;

    icache_control control_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_read  (mem_read),
        .status    (status),
        .pmem_resp (pmem_resp),
        .ctrl      (ctrl),
        .mem_resp  (mem_resp),
        .pmem_read (pmem_read)
    );

    icache_datapath #(
        .num_sets (num_sets)
    ) datapath_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_address  (mem_address),
        .ctrl         (ctrl),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address)
    );

endmodule

/* hw/icache_control.sv */
`timescale 1ns/1ps

module icache_control
    import icache_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           mem_read,
    input  icache_status_t status,
    input  logic           pmem_resp,
    output icache_ctrl_t   ctrl,
    output logic           mem_resp,
    output logic           pmem_read
);

    // lookup serves hits, fill waits for the memory line
    typedef enum logic {
        lookup,
        fill
    } state_t;

    state_t state;
    state_t next_state;

    // outputs per state
    always_comb begin
        // defaults first
        ctrl      = '0;
        mem_resp  = 1'b0;
        pmem_read = 1'b0;

        unique case (state)
            lookup: begin
                // only a real read counts as hit or miss
                if (mem_read && (status.hit != 2'b00)) begin
                    mem_resp      = 1'b1;
                    ctrl.load_lru = 1'b1;
                    // hit in way 0 makes way 1 the victim, and the other way round
                    ctrl.lru_in   = status.hit[0];
                end
            end

            fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // install into the lru way
                    ctrl.fill_way[status.lru_way] = 1'b1;
                    ctrl.load_lru = 1'b1;
                    // freshly filled way is now most recent
                    ctrl.lru_in   = ~status.lru_way;
                end
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

    // next state
    always_comb begin
        next_state = state;
        unique case (state)
            lookup: begin
                // miss goes to fill
                if (mem_read && (status.hit == 2'b00)) begin
                    next_state = fill;
                end
            end

            fill: begin
                // back to lookup, the access then hits
                if (pmem_resp) begin
                    next_state = lookup;
                end
            end

            default: begin
                next_state = lookup;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lookup;
        end else begin
            state <= next_state;
        end
    end

    // processor response never overlaps a memory fetch
    assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_resp && pmem_read));

    // a way is written only with the memory line present
    assert property (@(posedge clk) disable iff (!arst_n)
        (ctrl.fill_way != 2'b00) |-> pmem_resp);

endmodule

/* hw/icache_datapath.sv */
`timescale 1ns/1ps

module icache_datapath
    import icache_pkg::*;
#(
    parameter int num_sets = 8
) (
    input  logic           clk,
    input  logic           arst_n,
    input  addr_t          mem_address,
    input  icache_ctrl_t   ctrl,
    input  line_t          pmem_rdata,
    output icache_status_t status,
    output word_t          mem_rdata,
    output addr_t          pmem_address
);

    // address split widths
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = 32 - offset_bits - index_bits;
    // byte bits inside a word
    localparam int byte_bits  = 2;
    localparam int word_bits  = offset_bits - byte_bits;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    // word number within the line
    logic [word_bits-1:0]  word_sel;

    // way outputs
    logic                  valid0;
    logic                  valid1;
    logic [tag_bits-1:0]   tag0;
    logic [tag_bits-1:0]   tag1;
    line_t                 line0;
    line_t                 line1;
    line_t                 hit_line;

    // lru bit per set, names the way to replace
    logic [num_sets-1:0]   lru_q;

    // tag | index | word | byte
    assign tag      = mem_address[31 -: tag_bits];
    assign index    = mem_address[offset_bits +: index_bits];
    assign word_sel = mem_address[byte_bits +: word_bits];

    // line-aligned fetch address
    assign pmem_address = {mem_address[31:offset_bits], {offset_bits{1'b0}}};

    icache_way #(
        .num_sets (num_sets)
    ) way0_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .index    (index),
        .tag_in   (tag),
        .fill     (ctrl.fill_way[0]),
        .line_in  (pmem_rdata),
        .valid    (valid0),
        .tag_out  (tag0),
        .line_out (line0)
    );

    icache_way #(
        .num_sets (num_sets)
    ) way1_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .index    (index),
        .tag_in   (tag),
        .fill     (ctrl.fill_way[1]),
        .line_in  (pmem_rdata),
        .valid    (valid1),
        .tag_out  (tag1),
        .line_out (line1)
    );

    // lru state, all sets point at way 0 after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (ctrl.load_lru) begin
            lru_q[index] <= ctrl.lru_in;
        end
    end

    // hit vector and status
    always_comb begin
        status.hit[0] = valid0 && (tag0 == tag);
        status.hit[1] = valid1 && (tag1 == tag);
        status.lru_way = lru_q[index];
    end

    // way mux then word select
    assign hit_line  = status.hit[1] ? line1 : line0;
    assign mem_rdata = hit_line[word_sel*32 +: 32];

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!arst_n)
        status.hit != 2'b11);

endmodule

/* hw/icache_way.sv */
`timescale 1ns/1ps

module icache_way
    import icache_pkg::*;
#(
    parameter int num_sets = 8
) (
    input  logic                                           clk,
    input  logic                                           arst_n,
    // set select from the datapath address split
    input  logic [$clog2(num_sets)-1:0]                    index,
    input  logic [31-offset_bits-$clog2(num_sets):0]       tag_in,
    // write strobe for this way
    input  logic                                           fill,
    input  line_t                                          line_in,
    output logic                                           valid,
    output logic [31-offset_bits-$clog2(num_sets):0]       tag_out,
    output line_t                                          line_out
);

    // widths derived from set count
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = 32 - offset_bits - index_bits;

    // one valid bit per set
    logic [num_sets-1:0] valid_q;

    // tag store
    logic [tag_bits-1:0] tag_array [num_sets];

    // line store
    line_t line_array [num_sets];

    // valid bits cleared on reset so every set starts empty
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill) begin
            // line becomes valid on the fill edge
            valid_q[index] <= 1'b1;
        end
    end

    // tag and line written together with valid
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_array[index]  <= tag_in;
            line_array[index] <= line_in;
        end
    end

    // combinational read at index
    always_comb begin
        valid    = valid_q[index];
        tag_out  = tag_array[index];
        line_out = line_array[index];
    end

endmodule

/* hw/icache_pkg.sv */
package icache_pkg;

    // byte offset bits within one 32-byte line
    localparam int offset_bits = 5;

    // processor byte address
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // full line, eight words, word 0 in the low bits
    typedef logic [255:0] line_t;

    // control to datapath
    typedef struct packed {
        // per-way write strobe for line, tag and valid
        logic [1:0] fill_way;
        // update lru bit of the indexed set
        logic       load_lru;
        // way to mark as least recently used
        logic       lru_in;
    } icache_ctrl_t;

    // datapath to control
    typedef struct packed {
        // one-hot or zero
        logic [1:0] hit;
        // lru bit of the indexed set
        logic       lru_way;
    } icache_status_t;

endpackage
